/* source/core_defines.svh */
`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

// Width of one data word and of the ALU datapath
`define CORE_DATA_BIT 32

// Byte address width, shared by pc_4 and data addresses
`define CORE_ADDR_BIT 32

// Register file index width
`define CORE_REG_BIT 5

// Data memory depth in 32-bit words, a power of two
`define CORE_DM_WORDS 256

`endif

/* source/core_pkg.sv */
package core_pkg;

    // ALU operation selected by decode
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_NOR  = 4'd5,
        ALU_SLT  = 4'd6,
        ALU_SLTU = 4'd7,
        ALU_SLL  = 4'd8,
        ALU_SRL  = 4'd9,
        ALU_SRA  = 4'd10,
        ALU_LUI  = 4'd11
    } alu_op_e;

    // Nine memory operations do not fit in three bits, so this one is four wide
    typedef enum logic [3:0] {
        DM_NONE = 4'd0,
        DM_LB   = 4'd1,
        DM_LBU  = 4'd2,
        DM_LH   = 4'd3,
        DM_LHU  = 4'd4,
        DM_LW   = 4'd5,
        DM_SB   = 4'd6,
        DM_SH   = 4'd7,
        DM_SW   = 4'd8
    } dm_op_e;

    typedef enum logic [1:0] {
        WB_ALU = 2'd0,
        WB_MEM = 2'd1,
        WB_PC4 = 2'd2
    } wb_sel_e;

endpackage

/* source/alu_unit.sv */
`timescale 1ns/10ps
`include "core_defines.svh"

module alu_unit (
    input  core_pkg::alu_op_e          alu_op,
    input  logic [`CORE_DATA_BIT-1:0]  rs_data,
    input  logic [`CORE_DATA_BIT-1:0]  rt_data,
    input  logic [15:0]                imm16,
    input  logic                       use_imm,
    input  logic                       imm_signed,
    output logic [`CORE_DATA_BIT-1:0]  alu_res,
    output logic [`CORE_DATA_BIT-1:0]  store_data
);

    logic [`CORE_DATA_BIT-1:0] imm_ext;
    logic [`CORE_DATA_BIT-1:0] op_b;
    logic [4:0]                shamt;

    // Sign extension for arithmetic immediates, zero extension for logical ones
    always_comb begin
        if (imm_signed) begin
            imm_ext = {{(`CORE_DATA_BIT - 16){imm16[15]}}, imm16};
        end else begin
            imm_ext = {{(`CORE_DATA_BIT - 16){1'b0}}, imm16};
        end
    end

    assign op_b  = use_imm ? imm_ext : rt_data;
    assign shamt = imm16[10:6];

    // Shifts act on rt as in MIPS, the amount is the shamt field
    always_comb begin
        case (alu_op)
            core_pkg::ALU_ADD: begin
                alu_res = rs_data + op_b;
            end
            core_pkg::ALU_SUB: begin
                alu_res = rs_data - op_b;
            end
            core_pkg::ALU_AND: begin
                alu_res = rs_data & op_b;
            end
            core_pkg::ALU_OR: begin
                alu_res = rs_data | op_b;
            end
            core_pkg::ALU_XOR: begin
                alu_res = rs_data ^ op_b;
            end
            core_pkg::ALU_NOR: begin
                alu_res = ~(rs_data | op_b);
            end
            core_pkg::ALU_SLT: begin
                alu_res = {{(`CORE_DATA_BIT - 1){1'b0}}, $signed(rs_data) < $signed(op_b)};
            end
            core_pkg::ALU_SLTU: begin
                alu_res = {{(`CORE_DATA_BIT - 1){1'b0}}, rs_data < op_b};
            end
            core_pkg::ALU_SLL: begin
                alu_res = rt_data << shamt;
            end
            core_pkg::ALU_SRL: begin
                alu_res = rt_data >> shamt;
            end
            core_pkg::ALU_SRA: begin
                alu_res = $signed(rt_data) >>> shamt;
            end
            core_pkg::ALU_LUI: begin
                alu_res = {imm16, {(`CORE_DATA_BIT - 16){1'b0}}};
            end
            default: begin
                alu_res = '0;
            end
        endcase
    end

    assign store_data = rt_data;

endmodule

/* source/ex_mem_reg.sv */
`timescale 1ns/10ps
`include "core_defines.svh"

module ex_mem_reg (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       en,
    input  logic                       clear,
    input  logic [`CORE_ADDR_BIT-1:0]  pc_4_in,
    input  logic [`CORE_DATA_BIT-1:0]  alu_res_in,
    input  logic [`CORE_DATA_BIT-1:0]  store_data_in,
    input  logic                       regfile_w_en_in,
    input  logic [`CORE_REG_BIT-1:0]   regfile_req_w_in,
    input  core_pkg::dm_op_e           dm_op_in,
    input  core_pkg::wb_sel_e          wb_sel_in,
    output logic [`CORE_ADDR_BIT-1:0]  pc_4,
    output logic [`CORE_DATA_BIT-1:0]  alu_res,
    output logic [`CORE_DATA_BIT-1:0]  store_data,
    output logic                       regfile_w_en,
    output logic [`CORE_REG_BIT-1:0]   regfile_req_w,
    output core_pkg::dm_op_e           dm_op,
    output core_pkg::wb_sel_e          wb_sel
);

    // Clear wins over en, so a flush during a stall still drops the slot
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc_4          <= '0;
            alu_res       <= '0;
            store_data    <= '0;
            regfile_w_en  <= 1'b0;
            regfile_req_w <= '0;
            dm_op         <= core_pkg::DM_NONE;
            wb_sel        <= core_pkg::WB_ALU;
        end else if (clear) begin
            pc_4          <= '0;
            alu_res       <= '0;
            store_data    <= '0;
            regfile_w_en  <= 1'b0;
            regfile_req_w <= '0;
            dm_op         <= core_pkg::DM_NONE;
            wb_sel        <= core_pkg::WB_ALU;
        end else if (en) begin
            pc_4          <= pc_4_in;
            alu_res       <= alu_res_in;
            store_data    <= store_data_in;
            regfile_w_en  <= regfile_w_en_in;
            regfile_req_w <= regfile_req_w_in;
            dm_op         <= dm_op_in;
            wb_sel        <= wb_sel_in;
        end
    end

    // A flushed slot must neither write memory nor write back
    a_clear_bubble: assert property (
        @(posedge clk) disable iff (!rst_n)
        clear |=> (!regfile_w_en && dm_op == core_pkg::DM_NONE)
    ) else $error("ex_mem_reg: slot not a bubble after clear");

endmodule

/* source/data_mem.sv */
`timescale 1ns/10ps
`include "core_defines.svh"

module data_mem (
    input  logic                       clk,
    input  logic                       en,
    input  logic [`CORE_ADDR_BIT-1:0]  addr,
    input  logic [`CORE_DATA_BIT-1:0]  store_data,
    input  core_pkg::dm_op_e           dm_op,
    output logic [`CORE_DATA_BIT-1:0]  load_data
);

    localparam int IDX_BIT = $clog2(`CORE_DM_WORDS);

    logic [31:0]        mem [`CORE_DM_WORDS];
    logic [IDX_BIT-1:0] idx;
    logic [3:0]         lane_mask;
    logic [31:0]        lane_data;
    logic [31:0]        word;
    logic [7:0]         rd_byte;
    logic [15:0]        rd_half;

    assign idx = addr[IDX_BIT+1:2];

    // Replicate the store data so every lane already holds the right bytes
    always_comb begin
        lane_mask = 4'b0000;
        lane_data = store_data;
        case (dm_op)
            core_pkg::DM_SB: begin
                lane_mask = 4'b0001 << addr[1:0];
                lane_data = {4{store_data[7:0]}};
            end
            core_pkg::DM_SH: begin
                lane_mask = addr[1] ? 4'b1100 : 4'b0011;
                lane_data = {2{store_data[15:0]}};
            end
            core_pkg::DM_SW: begin
                lane_mask = 4'b1111;
            end
            default: begin
                lane_mask = 4'b0000;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (en) begin
            for (int i = 0; i < 4; i++) begin
                if (lane_mask[i]) begin
                    mem[idx][8*i +: 8] <= lane_data[8*i +: 8];
                end
            end
        end
    end

    assign word    = mem[idx];
    assign rd_byte = word[8*addr[1:0] +: 8];
    assign rd_half = addr[1] ? word[31:16] : word[15:0];

    always_comb begin
        case (dm_op)
            core_pkg::DM_LB:  load_data = {{24{rd_byte[7]}}, rd_byte};
            core_pkg::DM_LBU: load_data = {24'b0, rd_byte};
            core_pkg::DM_LH:  load_data = {{16{rd_half[15]}}, rd_half};
            core_pkg::DM_LHU: load_data = {16'b0, rd_half};
            default:          load_data = word;
        endcase
    end

    a_half_align: assert property (
        @(posedge clk)
        (dm_op inside {core_pkg::DM_LH, core_pkg::DM_LHU, core_pkg::DM_SH}) |-> !addr[0]
    ) else $error("data_mem: misaligned halfword access at %h", addr);

    a_word_align: assert property (
        @(posedge clk)
        (dm_op inside {core_pkg::DM_LW, core_pkg::DM_SW}) |-> (addr[1:0] == 2'b00)
    ) else $error("data_mem: misaligned word access at %h", addr);

endmodule

/* source/mem_wb_reg.sv */
`timescale 1ns/10ps
`include "core_defines.svh"

module mem_wb_reg (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       en,
    input  core_pkg::wb_sel_e          wb_sel,
    input  logic [`CORE_DATA_BIT-1:0]  alu_res,
    input  logic [`CORE_DATA_BIT-1:0]  load_data,
    input  logic [`CORE_ADDR_BIT-1:0]  pc_4,
    input  logic                       regfile_w_en,
    input  logic [`CORE_REG_BIT-1:0]   regfile_req_w,
    output logic                       wb_w_en,
    output logic [`CORE_REG_BIT-1:0]   wb_req_w,
    output logic [`CORE_DATA_BIT-1:0]  wb_data
);

    logic [`CORE_DATA_BIT-1:0] sel_data;

    always_comb begin
        case (wb_sel)
            core_pkg::WB_MEM: sel_data = load_data;
            core_pkg::WB_PC4: sel_data = pc_4;
            default:          sel_data = alu_res;
        endcase
    end

    // Register 0 is hardwired, writes to it are dropped here
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_w_en  <= 1'b0;
            wb_req_w <= '0;
            wb_data  <= '0;
        end else if (en) begin
            wb_w_en  <= regfile_w_en && (regfile_req_w != '0);
            wb_req_w <= regfile_req_w;
            wb_data  <= sel_data;
        end
    end

    a_no_r0_write: assert property (
        @(posedge clk) disable iff (!rst_n)
        wb_w_en |-> (wb_req_w != '0)
    ) else $error("mem_wb_reg: write enable asserted for register 0");

endmodule

/* source/exmem_top.sv */
`timescale 1ns/10ps
`include "core_defines.svh"

module exmem_top (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       stall,
    input  logic                       flush,
    input  logic [`CORE_ADDR_BIT-1:0]  pc_4,
    input  core_pkg::alu_op_e          alu_op,
    input  logic [`CORE_DATA_BIT-1:0]  rs_data,
    input  logic [`CORE_DATA_BIT-1:0]  rt_data,
    input  logic [15:0]                imm16,
    input  logic                       use_imm,
    input  logic                       imm_signed,
    input  logic                       regfile_w_en,
    input  logic [`CORE_REG_BIT-1:0]   regfile_req_w,
    input  core_pkg::dm_op_e           dm_op,
    input  core_pkg::wb_sel_e          wb_sel,
    output logic                       wb_w_en,
    output logic [`CORE_REG_BIT-1:0]   wb_req_w,
    output logic [`CORE_DATA_BIT-1:0]  wb_data
);

    logic                      en;
    logic [`CORE_DATA_BIT-1:0] ex_alu_res;
    logic [`CORE_DATA_BIT-1:0] ex_store_data;
    logic [`CORE_ADDR_BIT-1:0] s3_pc_4;
    logic [`CORE_DATA_BIT-1:0] s3_alu_res;
    logic [`CORE_DATA_BIT-1:0] s3_store_data;
    logic                      s3_w_en;
    logic [`CORE_REG_BIT-1:0]  s3_req_w;
    core_pkg::dm_op_e          s3_dm_op;
    core_pkg::wb_sel_e         s3_wb_sel;
    logic [`CORE_DATA_BIT-1:0] s3_load_data;

    // One stall freezes stage 3, the memory write and writeback together
    assign en = ~stall;

    alu_unit u_alu (
        .alu_op(alu_op), .rs_data(rs_data), .rt_data(rt_data), .imm16(imm16),
        .use_imm(use_imm), .imm_signed(imm_signed),
        .alu_res(ex_alu_res), .store_data(ex_store_data)
    );

    ex_mem_reg u_ex_mem (
        .clk(clk), .rst_n(rst_n), .en(en), .clear(flush),
        .pc_4_in(pc_4), .alu_res_in(ex_alu_res), .store_data_in(ex_store_data),
        .regfile_w_en_in(regfile_w_en), .regfile_req_w_in(regfile_req_w),
        .dm_op_in(dm_op), .wb_sel_in(wb_sel),
        .pc_4(s3_pc_4), .alu_res(s3_alu_res), .store_data(s3_store_data),
        .regfile_w_en(s3_w_en), .regfile_req_w(s3_req_w),
        .dm_op(s3_dm_op), .wb_sel(s3_wb_sel)
    );

    data_mem u_dmem (
        .clk(clk), .en(en), .addr(s3_alu_res), .store_data(s3_store_data),
        .dm_op(s3_dm_op), .load_data(s3_load_data)
    );

    mem_wb_reg u_mem_wb (
        .clk(clk), .rst_n(rst_n), .en(en), .wb_sel(s3_wb_sel),
        .alu_res(s3_alu_res), .load_data(s3_load_data), .pc_4(s3_pc_4),
        .regfile_w_en(s3_w_en), .regfile_req_w(s3_req_w),
        .wb_w_en(wb_w_en), .wb_req_w(wb_req_w), .wb_data(wb_data)
    );

endmodule

/* tests/exmem_tb.sv */
`timescale 1ns/10ps
`include "core_defines.svh"

module exmem_tb;

    localparam logic [31:0] SEED = 32'h1550;
    localparam int N_ALU = 240;
    localparam int N_MEM = 30;
    localparam int N_PC = 10;
    localparam int N_FLUSH = 8;
    localparam int N_MIX = 150;
    localparam int MAX_STALL = 2;
    localparam int REGION_WORDS = 16;
    // Reset, every issued slot, two settle steps per test and the worst stall case
    localparam int STIM_CYCLES = 3 + 4 + N_ALU + REGION_WORDS + 6 * N_MEM + 2 * N_PC
        + 2 * N_FLUSH + N_MIX * (1 + MAX_STALL) + 6 * 2;
    localparam int CYCLE_LIMIT = STIM_CYCLES + 50;

    logic                      clk;
    logic                      rst_n;
    logic                      stall;
    logic                      flush;
    logic [`CORE_ADDR_BIT-1:0] pc_4;
    core_pkg::alu_op_e         alu_op;
    logic [`CORE_DATA_BIT-1:0] rs_data;
    logic [`CORE_DATA_BIT-1:0] rt_data;
    logic [15:0]               imm16;
    logic                      use_imm;
    logic                      imm_signed;
    logic                      regfile_w_en;
    logic [`CORE_REG_BIT-1:0]  regfile_req_w;
    core_pkg::dm_op_e          dm_op;
    core_pkg::wb_sel_e         wb_sel;
    logic                      wb_w_en;
    logic [`CORE_REG_BIT-1:0]  wb_req_w;
    logic [`CORE_DATA_BIT-1:0] wb_data;

    // Expected write port per slot, packed as {w_en, req_w, data}
    logic [37:0] exp_q [$];
    logic [31:0] shadow [`CORE_DM_WORDS];
    logic        check_on = 1'b0;
    logic        exp_w_en = 1'b0;
    logic [4:0]  exp_req_w = 5'd0;
    logic [31:0] exp_data = 32'd0;
    int          errors = 0;
    int          tests_passed = 0;
    int          tests_failed = 0;
    int          cycle_count = 0;

    exmem_top dut (.*);

    always #10 clk = ~clk;

    function automatic logic [31:0] calc_alu(input core_pkg::alu_op_e op,
                                             input logic [31:0] rs, input logic [31:0] rt,
                                             input logic [15:0] imm, input logic imm_en,
                                             input logic sext);
        logic [31:0] b;
        logic [63:0] wide;
        logic [4:0]  sh;
        logic        lt;
        b = imm_en ? (sext ? {{16{imm[15]}}, imm} : {16'h0000, imm}) : rt;
        sh = imm[10:6];
        wide = {{32{rt[31]}}, rt} >> sh;
        // Signed compare from the sign bits, unsigned compare when they agree
        lt = (rs[31] != b[31]) ? rs[31] : (rs < b);
        case (op)
            core_pkg::ALU_ADD:  return rs + b;
            core_pkg::ALU_SUB:  return rs + ~b + 32'd1;
            core_pkg::ALU_AND:  return rs & b;
            core_pkg::ALU_OR:   return rs | b;
            core_pkg::ALU_XOR:  return rs ^ b;
            core_pkg::ALU_NOR:  return ~rs & ~b;
            core_pkg::ALU_SLT:  return {31'd0, lt};
            core_pkg::ALU_SLTU: return {31'd0, rs < b};
            core_pkg::ALU_SLL:  return rt << sh;
            core_pkg::ALU_SRL:  return rt >> sh;
            core_pkg::ALU_SRA:  return wide[31:0];
            core_pkg::ALU_LUI:  return {imm, 16'h0000};
            default:            return 32'd0;
        endcase
    endfunction

    // Loads read the shadow word before this slot's own store is merged in
    task automatic predict_slot(output logic [37:0] slot);
        logic [31:0] addr;
        logic [31:0] word;
        logic [31:0] ld;
        logic [31:0] wb_val;
        logic [7:0]  bsel;
        logic [15:0] hsel;
        logic [1:0]  off;
        int          w;
        addr = calc_alu(alu_op, rs_data, rt_data, imm16, use_imm, imm_signed);
        w = int'(addr[31:2]) % `CORE_DM_WORDS;
        off = addr[1:0];
        word = shadow[w];
        bsel = 8'(word >> (8 * off));
        hsel = 16'(word >> (16 * off[1]));
        ld = 32'd0;
        case (dm_op)
            core_pkg::DM_LB:  ld = {{24{bsel[7]}}, bsel};
            core_pkg::DM_LBU: ld = {24'h000000, bsel};
            core_pkg::DM_LH:  ld = {{16{hsel[15]}}, hsel};
            core_pkg::DM_LHU: ld = {16'h0000, hsel};
            core_pkg::DM_LW:  ld = word;
            core_pkg::DM_SB:  shadow[w][8 * off +: 8] = rt_data[7:0];
            core_pkg::DM_SH:  shadow[w][16 * off[1] +: 16] = rt_data[15:0];
            core_pkg::DM_SW:  shadow[w] = rt_data;
            default:          ld = 32'd0;
        endcase
        case (wb_sel)
            core_pkg::WB_MEM: wb_val = ld;
            core_pkg::WB_PC4: wb_val = pc_4;
            default:          wb_val = addr;
        endcase
        slot = {regfile_w_en && (regfile_req_w != 5'd0), regfile_req_w, wb_val};
    endtask

    // Each unstalled edge moves the queue head into writeback and queues the new slot
    always @(posedge clk) begin
        logic [37:0] slot;
        if (rst_n && !stall) begin
            if (exp_q.size() == 0) begin
                slot = '0;
            end else begin
                slot = exp_q.pop_front();
            end
            exp_w_en  <= slot[37];
            exp_req_w <= slot[36:32];
            exp_data  <= slot[31:0];
            check_on  <= 1'b1;
            if (flush) begin
                slot = '0;
            end else begin
                predict_slot(slot);
            end
            exp_q.push_back(slot);
        end
    end

    a_reset_idle: assert property (
        @(posedge clk) !rst_n |-> (!wb_w_en && wb_data == '0)
    ) else begin
        errors++;
        $display("MISMATCH wb_w_en/wb_data in reset expected 0/%h got %h/%h",
                 32'd0, $sampled(wb_w_en), $sampled(wb_data));
    end

    a_wb_w_en: assert property (
        @(posedge clk) disable iff (!rst_n) check_on |-> (wb_w_en == exp_w_en)
    ) else begin
        errors++;
        $display("MISMATCH wb_w_en expected %h got %h", $sampled(exp_w_en), $sampled(wb_w_en));
    end

    a_wb_req_w: assert property (
        @(posedge clk) disable iff (!rst_n) check_on |-> (wb_req_w == exp_req_w)
    ) else begin
        errors++;
        $display("MISMATCH wb_req_w expected %h got %h",
                 $sampled(exp_req_w), $sampled(wb_req_w));
    end

    a_wb_data: assert property (
        @(posedge clk) disable iff (!rst_n) check_on |-> (wb_data == exp_data)
    ) else begin
        errors++;
        $display("MISMATCH wb_data expected %h got %h", $sampled(exp_data), $sampled(wb_data));
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    task automatic step(input int max_stall);
        int n;
        n = (max_stall > 0) ? int'($urandom_range(max_stall, 0)) : 0;
        if (n > 0) begin
            stall = 1'b1;
            repeat (n) begin
                @(posedge clk);
                #2;
            end
            stall = 1'b0;
        end
        @(posedge clk);
        #2;
    endtask

    task automatic drive_idle();
        pc_4          = '0;
        alu_op        = core_pkg::ALU_ADD;
        rs_data       = '0;
        rt_data       = '0;
        imm16         = '0;
        use_imm       = 1'b0;
        imm_signed    = 1'b0;
        regfile_w_en  = 1'b0;
        regfile_req_w = '0;
        dm_op         = core_pkg::DM_NONE;
        wb_sel        = core_pkg::WB_ALU;
    endtask

    task automatic drive_alu(input core_pkg::alu_op_e op, input logic [4:0] req);
        pc_4          = $urandom;
        alu_op        = op;
        rs_data       = $urandom;
        rt_data       = $urandom;
        imm16         = 16'($urandom);
        use_imm       = 1'($urandom);
        imm_signed    = 1'($urandom);
        regfile_w_en  = 1'b1;
        regfile_req_w = req;
        dm_op         = core_pkg::DM_NONE;
        wb_sel        = core_pkg::WB_ALU;
    endtask

    // Address is base plus a signed offset, so the ALU add forms it
    task automatic drive_mem(input core_pkg::dm_op_e op, input logic [31:0] addr,
                             input logic [31:0] data);
        logic [15:0] ofs;
        logic        is_load;
        ofs = 16'($urandom_range(255, 0)) - 16'd128;
        is_load = op inside {core_pkg::DM_LB, core_pkg::DM_LBU, core_pkg::DM_LH,
                             core_pkg::DM_LHU, core_pkg::DM_LW};
        pc_4          = $urandom;
        alu_op        = core_pkg::ALU_ADD;
        rs_data       = addr - {{16{ofs[15]}}, ofs};
        rt_data       = data;
        imm16         = ofs;
        use_imm       = 1'b1;
        imm_signed    = 1'b1;
        regfile_w_en  = is_load;
        regfile_req_w = 5'($urandom_range(31, 1));
        dm_op         = op;
        wb_sel        = is_load ? core_pkg::WB_MEM : core_pkg::WB_ALU;
    endtask

    function automatic logic [31:0] pick_word();
        return $urandom_range(REGION_WORDS - 1, 0) << 2;
    endfunction

    function automatic logic [31:0] place(input core_pkg::dm_op_e op,
                                          input logic [31:0] word_addr);
        case (op)
            core_pkg::DM_LB, core_pkg::DM_LBU, core_pkg::DM_SB:
                return word_addr + $urandom_range(3, 0);
            core_pkg::DM_LH, core_pkg::DM_LHU, core_pkg::DM_SH:
                return word_addr + 2 * $urandom_range(1, 0);
            default:
                return word_addr;
        endcase
    endfunction

    function automatic core_pkg::alu_op_e any_op();
        return core_pkg::alu_op_e'(4'($urandom_range(11, 0)));
    endfunction

    task automatic settle();
        drive_idle();
        step(0);
        step(0);
    endtask

    task automatic finish_test(input string name, input int err_before);
        if (errors == err_before) begin
            tests_passed++;
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d check errors", name, errors - err_before);
        end
    endtask

    initial begin
        core_pkg::dm_op_e st_ops [3] = '{core_pkg::DM_SB, core_pkg::DM_SH, core_pkg::DM_SW};
        core_pkg::dm_op_e ld_ops [5] = '{core_pkg::DM_LB, core_pkg::DM_LBU, core_pkg::DM_LH,
                                         core_pkg::DM_LHU, core_pkg::DM_LW};
        core_pkg::dm_op_e op;
        logic [31:0] wa;
        int e0;
        int k;
        clk = 1'b0;
        rst_n = 1'b0;
        stall = 1'b0;
        flush = 1'b0;
        drive_idle();
        void'($urandom(SEED));

        e0 = errors;
        repeat (3) @(posedge clk);
        #2;
        rst_n = 1'b1;
        repeat (4) step(0);
        settle();
        finish_test("reset_idle", e0);

        e0 = errors;
        for (int i = 0; i < N_ALU; i++) begin
            drive_alu(core_pkg::alu_op_e'(4'(i % 12)), 5'($urandom_range(31, 1)));
            step(0);
        end
        settle();
        finish_test("alu_ops", e0);

        e0 = errors;
        for (int i = 0; i < REGION_WORDS; i++) begin
            drive_mem(core_pkg::DM_SW, 32'(i * 4), $urandom);
            step(0);
        end
        for (int r = 0; r < N_MEM; r++) begin
            wa = pick_word();
            op = st_ops[$urandom_range(2, 0)];
            drive_mem(op, place(op, wa), $urandom);
            step(0);
            foreach (ld_ops[j]) begin
                drive_mem(ld_ops[j], place(ld_ops[j], wa), $urandom);
                step(0);
            end
        end
        settle();
        finish_test("load_store", e0);

        e0 = errors;
        for (int i = 0; i < N_PC; i++) begin
            drive_alu(any_op(), 5'($urandom_range(31, 1)));
            wb_sel = core_pkg::WB_PC4;
            step(0);
        end
        for (int i = 0; i < N_PC; i++) begin
            drive_alu(any_op(), 5'd0);
            step(0);
        end
        settle();
        finish_test("pc4_and_r0", e0);

        // The flushed slot alternates between a store and a register write
        e0 = errors;
        for (int i = 0; i < N_FLUSH; i++) begin
            wa = pick_word();
            if (i % 2 == 0) begin
                drive_mem(core_pkg::DM_SW, wa, $urandom);
            end else begin
                drive_alu(any_op(), 5'($urandom_range(31, 1)));
            end
            flush = 1'b1;
            step(0);
            flush = 1'b0;
            drive_mem(core_pkg::DM_LW, wa, $urandom);
            step(0);
        end
        settle();
        finish_test("flush_bubble", e0);

        e0 = errors;
        for (int i = 0; i < N_MIX; i++) begin
            k = int'($urandom_range(3, 0));
            wa = pick_word();
            if (k == 0) begin
                drive_alu(any_op(), 5'($urandom_range(31, 0)));
            end else if (k == 1) begin
                op = st_ops[$urandom_range(2, 0)];
                drive_mem(op, place(op, wa), $urandom);
            end else if (k == 2) begin
                op = ld_ops[$urandom_range(4, 0)];
                drive_mem(op, place(op, wa), $urandom);
            end else begin
                drive_alu(any_op(), 5'($urandom_range(31, 1)));
                wb_sel = core_pkg::WB_PC4;
            end
            step(MAX_STALL);
        end
        settle();
        finish_test("stall_mix", e0);

        $display("Summary: %0d tests ok, %0d tests with errors, %0d check errors",
                 tests_passed, tests_failed, errors);
        if (tests_failed == 0 && errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* sim.f */
+incdir+source
source/core_pkg.sv
source/alu_unit.sv
source/ex_mem_reg.sv
source/data_mem.sv
source/mem_wb_reg.sv
source/exmem_top.sv
tests/exmem_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= exmem_tb
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

SOURCES := $(wildcard source/*.sv source/*.svh tests/*.sv)

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "TEST RESULT: PASS" $(LOG); then \
		echo "Pass message found in $(LOG)"; \
	else \
		echo "Pass message missing from $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
